// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Apple II bus diagnostic testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module a2_bus_diag_tb -o a2_bus_diag_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/a2_bus_diag_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
fi
exit "$status"

// File: source/a2_bus_diag_top.sv
`timescale 1ns/1ns

module a2_bus_diag_top
    import a2bus_pkg::*, diag_regs_pkg::*;
(
    input  logic       clk_logic_w,
    input  logic       system_reset_n_w,

    // Apple II bus
    input  logic       a2_phi1_i,
    input  a2_addr_t   a2_a_i,
    input  a2_data_t   a2_d_i,
    input  logic       a2_rw_n_i,
    input  logic       a2_m2sel_n_i,

    // Host register port
    input  axil_addr_t s_axil_awaddr_i,
    input  logic       s_axil_awvalid_i,
    output logic       s_axil_awready_o,
    input  axil_word_t s_axil_wdata_i,
    input  logic       s_axil_wvalid_i,
    output logic       s_axil_wready_o,
    output axil_resp_t s_axil_bresp_o,
    output logic       s_axil_bvalid_o,
    input  logic       s_axil_bready_i,
    input  axil_addr_t s_axil_araddr_i,
    input  logic       s_axil_arvalid_i,
    output logic       s_axil_arready_o,
    output axil_word_t s_axil_rdata_o,
    output axil_resp_t s_axil_rresp_o,
    output logic       s_axil_rvalid_o,
    input  logic       s_axil_rready_i
);

    logic        cycle_valid_w;
    a2_addr_t    cycle_addr_w;
    a2_data_t    cycle_data_w;
    logic        cycle_rw_n_w;
    logic        cycle_m2sel_n_w;
    logic        stats_clear_w;
    diag_count_t text_writes_w;
    diag_count_t bus_cycles_w;
    a2_addr_t    last_addr_w;
    a2_data_t    last_data_w;

    a2_cycle_capture u_capture (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .a2_phi1_i        (a2_phi1_i),
        .a2_a_i           (a2_a_i),
        .a2_d_i           (a2_d_i),
        .a2_rw_n_i        (a2_rw_n_i),
        .a2_m2sel_n_i     (a2_m2sel_n_i),
        .cycle_valid_o    (cycle_valid_w),
        .cycle_addr_o     (cycle_addr_w),
        .cycle_data_o     (cycle_data_w),
        .cycle_rw_n_o     (cycle_rw_n_w),
        .cycle_m2sel_n_o  (cycle_m2sel_n_w)
    );

    text_write_stats u_stats (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .cycle_valid_i    (cycle_valid_w),
        .cycle_addr_i     (cycle_addr_w),
        .cycle_data_i     (cycle_data_w),
        .cycle_rw_n_i     (cycle_rw_n_w),
        .cycle_m2sel_n_i  (cycle_m2sel_n_w),
        .stats_clear_i    (stats_clear_w),
        .text_writes_o    (text_writes_w),
        .bus_cycles_o     (bus_cycles_w),
        .last_addr_o      (last_addr_w),
        .last_data_o      (last_data_w)
    );

    diag_axil_regs u_regs (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .text_writes_i    (text_writes_w),
        .bus_cycles_i     (bus_cycles_w),
        .last_addr_i      (last_addr_w),
        .last_data_i      (last_data_w),
        .stats_clear_o    (stats_clear_w)
    );

endmodule

// File: source/a2_cycle_capture.sv
`timescale 1ns/1ns

module a2_cycle_capture
    import a2bus_pkg::*;
(
    input  logic     clk_logic_w,
    input  logic     system_reset_n_w,

    // Raw Apple II bus lines
    input  logic     a2_phi1_i,
    input  a2_addr_t a2_a_i,
    input  a2_data_t a2_d_i,
    input  logic     a2_rw_n_i,
    input  logic     a2_m2sel_n_i,

    // One captured bus cycle
    output logic     cycle_valid_o,
    output a2_addr_t cycle_addr_o,
    output a2_data_t cycle_data_o,
    output logic     cycle_rw_n_o,
    output logic     cycle_m2sel_n_o
);

    logic [PHI_SYNC_STAGES-1:0] phi_sync_r;
    logic                       phi_prev_r;
    logic                       phi_synced_w;
    logic                       phi_rise_w;

    assign phi_synced_w = phi_sync_r[PHI_SYNC_STAGES-1];
    assign phi_rise_w   = phi_synced_w & ~phi_prev_r;   // Low to high since last clock

    // phi1 is asynchronous to the logic clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            phi_sync_r <= '0;
            phi_prev_r <= 1'b0;
        end else begin
            phi_sync_r <= {phi_sync_r[PHI_SYNC_STAGES-2:0], a2_phi1_i};
            phi_prev_r <= phi_synced_w;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            cycle_valid_o <= 1'b0;
        end else begin
            cycle_valid_o <= phi_rise_w;   // Single clock pulse per bus cycle
        end
    end

    // Bus lines are stable well before phi1 rises
    always_ff @(posedge clk_logic_w) begin
        if (phi_rise_w) begin
            cycle_addr_o    <= a2_a_i;
            cycle_data_o    <= a2_d_i;
            cycle_rw_n_o    <= a2_rw_n_i;
            cycle_m2sel_n_o <= a2_m2sel_n_i;
        end
    end

endmodule

// File: source/a2bus_pkg.sv
package a2bus_pkg;

    // Apple II expansion bus widths
    typedef logic [15:0] a2_addr_t;   // CPU address bus A15..A0
    typedef logic [7:0]  a2_data_t;   // Data bus D7..D0

    // Primary text page of the 40x24 screen
    localparam a2_addr_t TEXT_PAGE_LO = 16'h0400;
    localparam a2_addr_t TEXT_PAGE_HI = 16'h07FF;

    // Flops between the raw phi1 pin and the logic clock domain
    localparam int PHI_SYNC_STAGES = 2;

endpackage

// File: source/diag_axil_regs.sv
`timescale 1ns/1ns

module diag_axil_regs
    import a2bus_pkg::*, diag_regs_pkg::*;
(
    input  logic        clk_logic_w,
    input  logic        system_reset_n_w,

    // AXI4-Lite write channels
    input  axil_addr_t  s_axil_awaddr_i,
    input  logic        s_axil_awvalid_i,
    output logic        s_axil_awready_o,
    input  axil_word_t  s_axil_wdata_i,
    input  logic        s_axil_wvalid_i,
    output logic        s_axil_wready_o,
    output axil_resp_t  s_axil_bresp_o,
    output logic        s_axil_bvalid_o,
    input  logic        s_axil_bready_i,

    // AXI4-Lite read channels
    input  axil_addr_t  s_axil_araddr_i,
    input  logic        s_axil_arvalid_i,
    output logic        s_axil_arready_o,
    output axil_word_t  s_axil_rdata_o,
    output axil_resp_t  s_axil_rresp_o,
    output logic        s_axil_rvalid_o,
    input  logic        s_axil_rready_i,

    // Statistics
    input  diag_count_t text_writes_i,
    input  diag_count_t bus_cycles_i,
    input  a2_addr_t    last_addr_i,
    input  a2_data_t    last_data_i,
    output logic        stats_clear_o
);

    logic       rd_accept_w;
    logic       wr_accept_w;
    axil_word_t rd_data_w;
    axil_resp_t rd_resp_w;
    logic       wr_ctrl_w;

    // One outstanding response per channel
    assign s_axil_arready_o = !s_axil_rvalid_o;
    assign rd_accept_w      = s_axil_arvalid_i && s_axil_arready_o;

    // Address and data are only taken together
    assign wr_accept_w      = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
    assign s_axil_awready_o = wr_accept_w;
    assign s_axil_wready_o  = wr_accept_w;
    assign wr_ctrl_w        = (s_axil_awaddr_i == REG_CTRL);

    always_comb begin
        rd_resp_w = RESP_OKAY;
        case (s_axil_araddr_i)
            REG_TEXT_WRITES: rd_data_w = {16'h0000, text_writes_i};
            REG_BUS_CYCLES:  rd_data_w = {16'h0000, bus_cycles_i};
            REG_LAST_WRITE:  rd_data_w = {8'h00, last_addr_i, last_data_i};
            REG_ID:          rd_data_w = DIAG_ID;
            REG_CTRL:        rd_data_w = '0;   // Write-only command bits
            default: begin
                rd_data_w = '0;
                rd_resp_w = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (rd_accept_w) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    // Snapshot of the statistics at the address handshake
    always_ff @(posedge clk_logic_w) begin
        if (rd_accept_w) begin
            s_axil_rdata_o <= rd_data_w;
            s_axil_rresp_o <= rd_resp_w;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            s_axil_bvalid_o <= 1'b0;
            s_axil_bresp_o  <= RESP_OKAY;
            stats_clear_o   <= 1'b0;
        end else begin
            stats_clear_o <= wr_accept_w && wr_ctrl_w && s_axil_wdata_i[CTRL_CLEAR_BIT];
            if (wr_accept_w) begin
                s_axil_bvalid_o <= 1'b1;
                s_axil_bresp_o  <= wr_ctrl_w ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

endmodule

// File: source/diag_regs_pkg.sv
package diag_regs_pkg;

    // AXI4-Lite register port widths
    typedef logic [4:0]  axil_addr_t;   // Byte address within the block
    typedef logic [31:0] axil_word_t;
    typedef logic [1:0]  axil_resp_t;

    // Statistics counters wrap at 16 bits
    typedef logic [15:0] diag_count_t;

    // Register map
    localparam axil_addr_t REG_TEXT_WRITES = 5'h00;   // Text page write count
    localparam axil_addr_t REG_BUS_CYCLES  = 5'h04;   // Total phi1 cycles seen
    localparam axil_addr_t REG_LAST_WRITE  = 5'h08;   // {8'h0, addr[15:0], data[7:0]}
    localparam axil_addr_t REG_ID          = 5'h0C;
    localparam axil_addr_t REG_CTRL        = 5'h10;   // Bit 0 clears the statistics

    // Bit position of the clear command in REG_CTRL
    localparam int CTRL_CLEAR_BIT = 0;

    // Block identifier read back from REG_ID
    localparam axil_word_t DIAG_ID = 32'hA2D1_0001;

    // Response codes
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

// File: source/text_write_stats.sv
`timescale 1ns/1ns

module text_write_stats
    import a2bus_pkg::*, diag_regs_pkg::*;
(
    input  logic        clk_logic_w,
    input  logic        system_reset_n_w,

    // Captured bus cycle
    input  logic        cycle_valid_i,
    input  a2_addr_t    cycle_addr_i,
    input  a2_data_t    cycle_data_i,
    input  logic        cycle_rw_n_i,
    input  logic        cycle_m2sel_n_i,

    input  logic        stats_clear_i,   // One clock pulse from the register block

    output diag_count_t text_writes_o,
    output diag_count_t bus_cycles_o,
    output a2_addr_t    last_addr_o,
    output a2_data_t    last_data_o
);

    logic in_text_page_w;
    logic text_write_w;

    assign in_text_page_w = (cycle_addr_i >= TEXT_PAGE_LO) && (cycle_addr_i <= TEXT_PAGE_HI);

    // CPU write to main memory text page
    assign text_write_w = cycle_valid_i && !cycle_rw_n_i && !cycle_m2sel_n_i && in_text_page_w;

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            bus_cycles_o <= '0;
        end else if (stats_clear_i) begin
            bus_cycles_o <= '0;   // Clear wins over a coincident cycle
        end else if (cycle_valid_i) begin
            bus_cycles_o <= bus_cycles_o + 1'b1;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            text_writes_o <= '0;
            last_addr_o   <= '0;
            last_data_o   <= '0;
        end else if (stats_clear_i) begin
            text_writes_o <= '0;
            last_addr_o   <= '0;
            last_data_o   <= '0;
        end else if (text_write_w) begin
            text_writes_o <= text_writes_o + 1'b1;
            last_addr_o   <= cycle_addr_i;
            last_data_o   <= cycle_data_i;
        end
    end

endmodule

// File: testbench/a2_bus_diag_checker.sv
`timescale 1ns/1ns

module a2_bus_diag_checker
    import diag_regs_pkg::*;
(
    input logic       clk_logic_w,
    input logic       system_reset_n_w,
    input logic       awvalid_i,
    input logic       wvalid_i,
    input logic       awready_i,
    input logic       wready_i,
    input logic       bvalid_i,
    input logic       bready_i,
    input axil_resp_t bresp_i,
    input logic       rvalid_i,
    input logic       rready_i,
    input axil_word_t rdata_i,
    input axil_resp_t rresp_i
);

    // A pending read response waits for the host
    read_held: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else $error("Read response dropped or changed before rready");

    write_held: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else $error("Write response dropped or changed before bready");

    // Synchronous reset clears both response channels
    reset_quiet: assert property (@(posedge clk_logic_w)
        !system_reset_n_w |=> !rvalid_i && !bvalid_i)
        else $error("Response valid high after a reset clock");

    aw_ready_gated: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        awready_i |-> awvalid_i && wvalid_i)
        else $error("awready raised without both write valids");

    w_ready_gated: assert property (@(posedge clk_logic_w) disable iff (!system_reset_n_w)
        wready_i |-> awvalid_i && wvalid_i)
        else $error("wready raised without both write valids");

endmodule

// File: testbench/a2_bus_diag_tb.sv
`timescale 1ns/1ns

module a2_bus_diag_tb
    import a2bus_pkg::*, diag_regs_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_CYCLES  = 40;

    logic        clk_logic_w;
    logic        system_reset_n_w;
    logic        a2_phi1_i;
    a2_addr_t    a2_a_i;
    a2_data_t    a2_d_i;
    logic        a2_rw_n_i;
    logic        a2_m2sel_n_i;
    axil_addr_t  s_axil_awaddr_i;
    logic        s_axil_awvalid_i;
    logic        s_axil_awready_o;
    axil_word_t  s_axil_wdata_i;
    logic        s_axil_wvalid_i;
    logic        s_axil_wready_o;
    axil_resp_t  s_axil_bresp_o;
    logic        s_axil_bvalid_o;
    logic        s_axil_bready_i;
    axil_addr_t  s_axil_araddr_i;
    logic        s_axil_arvalid_i;
    logic        s_axil_arready_o;
    axil_word_t  s_axil_rdata_o;
    axil_resp_t  s_axil_rresp_o;
    logic        s_axil_rvalid_o;
    logic        s_axil_rready_i;

    // Reference model of the statistics
    diag_count_t model_cycles;
    diag_count_t model_text_writes;
    a2_addr_t    model_last_addr;
    a2_data_t    model_last_data;
    logic [31:0] lfsr_state;

    a2_bus_diag_top uut (.*);

    bind a2_bus_diag_top a2_bus_diag_checker u_checker (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .awvalid_i        (s_axil_awvalid_i),
        .wvalid_i         (s_axil_wvalid_i),
        .awready_i        (s_axil_awready_o),
        .wready_i         (s_axil_wready_o),
        .bvalid_i         (s_axil_bvalid_o),
        .bready_i         (s_axil_bready_i),
        .bresp_i          (s_axil_bresp_o),
        .rvalid_i         (s_axil_rvalid_o),
        .rready_i         (s_axil_rready_i),
        .rdata_i          (s_axil_rdata_o),
        .rresp_i          (s_axil_rresp_o)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #50 clk_logic_w = ~clk_logic_w;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input axil_word_t exp, input axil_word_t act);
        assert (act == exp)
            else abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    // One phi1 period of 8 clocks before the model takes the cycle
    task automatic drive_bus_cycle(input a2_addr_t addr, input a2_data_t data,
                                   input logic rw_n, input logic m2sel_n);
        a2_a_i       <= addr;
        a2_d_i       <= data;
        a2_rw_n_i    <= rw_n;
        a2_m2sel_n_i <= m2sel_n;
        a2_phi1_i    <= 1'b1;
        repeat (4) @(posedge clk_logic_w);
        a2_phi1_i    <= 1'b0;
        repeat (4) @(posedge clk_logic_w);
        model_cycles = model_cycles + 16'd1;
        if (!rw_n && !m2sel_n && addr >= 16'h0400 && addr <= 16'h07FF) begin
            model_text_writes = model_text_writes + 16'd1;
            model_last_addr   = addr;
            model_last_data   = data;
        end
    endtask

    task automatic random_bus_cycle();
        logic [31:0] bits;
        a2_addr_t    addr;
        a2_data_t    data;
        logic        rw_n;
        bits = lfsr_bits(1);
        if (bits[0]) begin
            bits = lfsr_bits(10);
            addr = 16'h0400 + {6'b0, bits[9:0]};   // Inside the text page
        end else begin
            bits = lfsr_bits(16);
            addr = bits[15:0];
        end
        bits = lfsr_bits(8);
        data = bits[7:0];
        bits = lfsr_bits(1);
        rw_n = bits[0];
        bits = lfsr_bits(2);
        drive_bus_cycle(addr, data, rw_n, bits[1:0] == 2'b11);
    endtask

    // Read with rready held low for stall clocks after the address handshake
    task automatic read_register(input axil_addr_t addr, input int stall,
                                 output axil_word_t data, output axil_resp_t resp);
        int waited;
        s_axil_araddr_i  <= addr;
        s_axil_arvalid_i <= 1'b1;
        s_axil_rready_i  <= (stall == 0);
        waited = 0;
        do begin
            @(posedge clk_logic_w);
            waited++;
            if (!s_axil_arready_o && waited >= TIMEOUT_CYCLES)
                abort_run("Timed out waiting for arready");
        end while (!s_axil_arready_o);
        s_axil_arvalid_i <= 1'b0;
        if (stall > 0) begin
            repeat (stall) @(posedge clk_logic_w);
            s_axil_rready_i <= 1'b1;
        end
        waited = 0;
        do begin
            @(posedge clk_logic_w);
            waited++;
            if (!s_axil_rvalid_o && waited >= TIMEOUT_CYCLES)
                abort_run("Timed out waiting for rvalid");
        end while (!s_axil_rvalid_o);
        data = s_axil_rdata_o;
        resp = s_axil_rresp_o;
        s_axil_rready_i <= 1'b0;
    endtask

    // Write with bready held low for stall clocks after the address handshake
    task automatic write_register(input axil_addr_t addr, input axil_word_t wdata,
                                  input int stall, output axil_resp_t resp);
        int waited;
        s_axil_awaddr_i  <= addr;
        s_axil_wdata_i   <= wdata;
        s_axil_awvalid_i <= 1'b1;
        s_axil_wvalid_i  <= 1'b1;
        s_axil_bready_i  <= (stall == 0);
        waited = 0;
        do begin
            @(posedge clk_logic_w);
            waited++;
            if (!(s_axil_awready_o && s_axil_wready_o) && waited >= TIMEOUT_CYCLES)
                abort_run("Timed out waiting for awready and wready");
        end while (!(s_axil_awready_o && s_axil_wready_o));
        s_axil_awvalid_i <= 1'b0;
        s_axil_wvalid_i  <= 1'b0;
        if (stall > 0) begin
            repeat (stall) @(posedge clk_logic_w);
            s_axil_bready_i <= 1'b1;
        end
        waited = 0;
        do begin
            @(posedge clk_logic_w);
            waited++;
            if (!s_axil_bvalid_o && waited >= TIMEOUT_CYCLES)
                abort_run("Timed out waiting for bvalid");
        end while (!s_axil_bvalid_o);
        resp = s_axil_bresp_o;
        s_axil_bready_i <= 1'b0;
    endtask

    task automatic check_read(input string name, input axil_addr_t addr, input axil_word_t exp);
        axil_word_t data;
        axil_resp_t resp;
        read_register(addr, 0, data, resp);
        expect_value({name, " resp"}, {30'b0, RESP_OKAY}, {30'b0, resp});
        expect_value(name, exp, data);
    endtask

    task automatic check_stats(input string name);
        check_read({name, " text writes"}, REG_TEXT_WRITES, {16'h0, model_text_writes});
        check_read({name, " bus cycles"}, REG_BUS_CYCLES, {16'h0, model_cycles});
        check_read({name, " last write"}, REG_LAST_WRITE,
                   {8'h0, model_last_addr, model_last_data});
    endtask

    initial begin
        axil_word_t  data;
        axil_resp_t  resp;
        diag_count_t cycles_before;

        lfsr_state        = 32'hac0d_7587;
        model_cycles      = '0;
        model_text_writes = '0;
        model_last_addr   = '0;
        model_last_data   = '0;
        system_reset_n_w <= 1'b0;
        a2_phi1_i        <= 1'b0;
        a2_a_i           <= '0;
        a2_d_i           <= '0;
        a2_rw_n_i        <= 1'b1;
        a2_m2sel_n_i     <= 1'b1;
        s_axil_awaddr_i  <= '0;
        s_axil_awvalid_i <= 1'b0;
        s_axil_wdata_i   <= '0;
        s_axil_wvalid_i  <= 1'b0;
        s_axil_bready_i  <= 1'b0;
        s_axil_araddr_i  <= '0;
        s_axil_arvalid_i <= 1'b0;
        s_axil_rready_i  <= 1'b0;
        repeat (3) @(posedge clk_logic_w);
        system_reset_n_w <= 1'b1;

        check_stats("after reset");
        check_read("identifier", REG_ID, 32'hA2D1_0001);

        // Random traffic plus both edges of the text page
        repeat (RANDOM_CYCLES) random_bus_cycle();
        drive_bus_cycle(16'h03FF, 8'h11, 1'b0, 1'b0);
        drive_bus_cycle(16'h0400, 8'h22, 1'b0, 1'b0);
        drive_bus_cycle(16'h0800, 8'h33, 1'b0, 1'b0);
        drive_bus_cycle(16'h07FF, 8'h44, 1'b0, 1'b0);
        check_stats("random traffic");

        drive_bus_cycle(16'h0500, 8'h55, 1'b1, 1'b0);   // CPU read
        drive_bus_cycle(16'h0600, 8'h66, 1'b0, 1'b1);   // M2SEL high
        check_stats("read and M2SEL high");
        check_read("control readback", REG_CTRL, 32'h0);

        write_register(REG_CTRL, 32'h0, 4, resp);
        expect_value("clear bit low resp", {30'b0, RESP_OKAY}, {30'b0, resp});
        check_stats("clear bit low");
        write_register(REG_CTRL, 32'h1, 0, resp);
        expect_value("clear resp", {30'b0, RESP_OKAY}, {30'b0, resp});
        model_cycles      = '0;
        model_text_writes = '0;
        model_last_addr   = '0;
        model_last_data   = '0;
        check_stats("after clear");

        read_register(5'h14, 0, data, resp);
        expect_value("unmapped read resp", {30'b0, RESP_SLVERR}, {30'b0, resp});
        expect_value("unmapped read data", 32'h0, data);
        write_register(REG_ID, 32'h1234_5678, 0, resp);
        expect_value("id write resp", {30'b0, RESP_SLVERR}, {30'b0, resp});

        // Bus cycle runs while the read response is stalled
        repeat (4) random_bus_cycle();
        cycles_before = model_cycles;
        fork
            read_register(REG_BUS_CYCLES, 12, data, resp);
            begin
                repeat (2) @(posedge clk_logic_w);
                drive_bus_cycle(16'h0450, 8'h41, 1'b0, 1'b0);
            end
        join
        expect_value("stalled read resp", {30'b0, RESP_OKAY}, {30'b0, resp});
        expect_value("stalled read data", {16'h0, cycles_before}, data);
        check_stats("after stall");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
source/a2bus_pkg.sv
source/diag_regs_pkg.sv
source/a2_cycle_capture.sv
source/text_write_stats.sv
source/diag_axil_regs.sv
source/a2_bus_diag_top.sv
testbench/a2_bus_diag_checker.sv
testbench/a2_bus_diag_tb.sv
